// ==== include/drop_config.svh ====
`ifndef DROP_CONFIG_SVH
`define DROP_CONFIG_SVH

`define COORD_W         12
`define NUM_SLOTS       10                 // one slot per turn

`define LEFT_BOUND      20
`define RIGHT_BOUND     300
`define UP_BOUND        40                 // top line where the ball is steered
`define FLOOR_Y         240

`define START_X         170
`define FALL_STEP       3                  // pixels per falling cycle

`define EMPTY_X         0
`define EMPTY_Y         0

`define BALL_SIZE_0     8                  // reset size and the size used once the game is over
`define BALL_SIZE_1     10
`define BALL_SIZE_2     15
`define BALL_SIZE_3     20
`define BALL_SIZE_4     25

`define SIZE_SCHEDULE_0 `BALL_SIZE_3
`define SIZE_SCHEDULE_1 `BALL_SIZE_2
`define SIZE_SCHEDULE_2 `BALL_SIZE_4
`define SIZE_SCHEDULE_3 `BALL_SIZE_1
`define SIZE_SCHEDULE_4 `BALL_SIZE_4
`define SIZE_SCHEDULE_5 `BALL_SIZE_3
`define SIZE_SCHEDULE_6 `BALL_SIZE_1
`define SIZE_SCHEDULE_7 `BALL_SIZE_2
`define SIZE_SCHEDULE_8 `BALL_SIZE_3
`define SIZE_SCHEDULE_9 `BALL_SIZE_2

`endif

// ==== verilog/drop_pkg.sv ====
`include "drop_config.svh"

package drop_pkg;

    // screen coordinate that also holds the ball radius
    typedef logic [`COORD_W-1:0] coord_t;

    typedef logic [3:0] turn_t;                // 10 means the game is over

    typedef enum logic [1:0] {
        play_select,                           // steering along the top line
        play_falling,
        play_landed                            // a single cycle that ends the turn
    } play_state_t;

endpackage

// ==== verilog/drop_player_fsm.sv ====
`timescale 1ns/10ps
`include "drop_config.svh"

module drop_player_fsm
    import drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   drop,
    input  logic   left,
    input  logic   right,
    input  coord_t ball_size,
    output coord_t x_pos,
    output coord_t y_pos,
    output logic   landed
);

    play_state_t state;
    play_state_t next_state;
    coord_t      next_x;
    coord_t      next_y;
    coord_t      top_y;
    coord_t      floor_lim;
    coord_t      left_lim;
    coord_t      right_lim;
    coord_t      fall_y;

    // limits depend on the radius so the ball edge stays inside the field
    assign top_y     = coord_t'(`UP_BOUND) - ball_size;
    assign floor_lim = coord_t'(`FLOOR_Y) - ball_size;
    assign left_lim  = coord_t'(`LEFT_BOUND) + ball_size;
    assign right_lim = coord_t'(`RIGHT_BOUND) - ball_size;
    assign fall_y    = y_pos + coord_t'(`FALL_STEP);

    assign landed = (state == play_landed);

    always_comb begin
        next_state = state;
        next_x     = x_pos;
        next_y     = y_pos;
        case (state)
            play_select: begin
                next_y = top_y;                // follows the size once a new turn begins
                if (drop) begin
                    next_state = play_falling; // x is kept where the player left it
                end else if (left) begin
                    if (x_pos != left_lim) begin
                        next_x = x_pos - 1'b1;
                    end
                end else if (right) begin
                    if (x_pos != right_lim) begin
                        next_x = x_pos + 1'b1;
                    end
                end
            end
            play_falling: begin
                if (y_pos >= floor_lim) begin
                    next_state = play_landed;  // resting on the floor
                end else if (fall_y < floor_lim) begin
                    next_y = fall_y;
                end else begin
                    next_y = floor_lim;        // last step is shortened
                end
            end
            play_landed: begin
                next_state = play_select;
                next_x     = coord_t'(`START_X);
                next_y     = top_y;
            end
            default: begin
                next_state = play_select;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= play_select;
            x_pos <= coord_t'(`START_X);
            y_pos <= coord_t'(`UP_BOUND);
        end else begin
            state <= next_state;
            x_pos <= next_x;
            y_pos <= next_y;
        end
    end

    // the fall never sinks the ball into the floor
    a_fall_clamped : assert property (
        @(posedge clk) disable iff (rst)
        (state == play_falling) |=> (y_pos <= floor_lim)
    );

    a_landed_single : assert property (
        @(posedge clk) disable iff (rst)
        landed |=> !landed
    );

endmodule

// ==== verilog/turn_sequencer.sv ====
`timescale 1ns/10ps
`include "drop_config.svh"

module turn_sequencer
    import drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   landed,
    output turn_t  turn,
    output coord_t ball_size,
    output logic   finish
);

    coord_t sched_size;

    always_comb begin
        case (turn)
            4'd0:    sched_size = coord_t'(`SIZE_SCHEDULE_0);
            4'd1:    sched_size = coord_t'(`SIZE_SCHEDULE_1);
            4'd2:    sched_size = coord_t'(`SIZE_SCHEDULE_2);
            4'd3:    sched_size = coord_t'(`SIZE_SCHEDULE_3);
            4'd4:    sched_size = coord_t'(`SIZE_SCHEDULE_4);
            4'd5:    sched_size = coord_t'(`SIZE_SCHEDULE_5);
            4'd6:    sched_size = coord_t'(`SIZE_SCHEDULE_6);
            4'd7:    sched_size = coord_t'(`SIZE_SCHEDULE_7);
            4'd8:    sched_size = coord_t'(`SIZE_SCHEDULE_8);
            4'd9:    sched_size = coord_t'(`SIZE_SCHEDULE_9);
            default: sched_size = coord_t'(`BALL_SIZE_0);  // game over
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            turn      <= '0;
            ball_size <= coord_t'(`BALL_SIZE_0);
        end else begin
            // saturate so finish stays up after the last landing
            if (landed && (turn < turn_t'(`NUM_SLOTS))) begin
                turn <= turn + 1'b1;
            end
            ball_size <= sched_size;                        // one cycle behind turn
        end
    end

    assign finish = (turn == turn_t'(`NUM_SLOTS));

    // the counter stops at the last turn and never wraps
    a_turn_saturates : assert property (
        @(posedge clk) disable iff (rst)
        turn <= turn_t'(`NUM_SLOTS)
    );

endmodule

// ==== verilog/ball_slot_table.sv ====
`timescale 1ns/10ps
`include "drop_config.svh"

module ball_slot_table
    import drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  turn_t  turn,
    input  coord_t x_pos,
    input  coord_t y_pos,
    input  coord_t ball_size,
    output coord_t slot_x    [`NUM_SLOTS],
    output coord_t slot_y    [`NUM_SLOTS],
    output coord_t slot_size [`NUM_SLOTS]
);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                slot_x[i]    <= coord_t'(`EMPTY_X);
                slot_y[i]    <= coord_t'(`EMPTY_Y);
                slot_size[i] <= coord_t'(`BALL_SIZE_0);
            end
        end else if (turn < turn_t'(`NUM_SLOTS)) begin
            // the active slot tracks the live ball and freezes when turn moves on
            slot_x[turn]    <= x_pos;
            slot_y[turn]    <= y_pos;
            slot_size[turn] <= ball_size;
        end
    end

    genvar g;
    generate
        for (g = 0; g < `NUM_SLOTS; g++) begin : g_slot_chk
            // a finished turn keeps its record for the rest of the game
            a_slot_frozen : assert property (
                @(posedge clk) disable iff (rst)
                (turn > turn_t'(g)) |=> ($stable(slot_x[g]) && $stable(slot_y[g])
                                         && $stable(slot_size[g]))
            );
        end
    endgenerate

endmodule

// ==== verilog/drop_game_top.sv ====
`timescale 1ns/10ps
`include "drop_config.svh"

module drop_game_top
    import drop_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   drop,
    input  logic   left,
    input  logic   right,
    output coord_t slot_x    [`NUM_SLOTS],
    output coord_t slot_y    [`NUM_SLOTS],
    output coord_t slot_size [`NUM_SLOTS],
    output logic   finish
);

    coord_t x_pos;
    coord_t y_pos;
    coord_t ball_size;
    turn_t  turn;
    logic   landed;

    drop_player_fsm fsm_i (
        .clk       (clk),
        .rst       (rst),
        .drop      (drop),
        .left      (left),
        .right     (right),
        .ball_size (ball_size),
        .x_pos     (x_pos),
        .y_pos     (y_pos),
        .landed    (landed)
    );

    turn_sequencer seq_i (
        .clk       (clk),
        .rst       (rst),
        .landed    (landed),
        .turn      (turn),
        .ball_size (ball_size),
        .finish    (finish)
    );

    ball_slot_table table_i (
        .clk       (clk),
        .rst       (rst),
        .turn      (turn),
        .x_pos     (x_pos),
        .y_pos     (y_pos),
        .ball_size (ball_size),
        .slot_x    (slot_x),
        .slot_y    (slot_y),
        .slot_size (slot_size)
    );

endmodule

// ==== verif/drop_game_tb.sv ====
`timescale 1ns/10ps
`include "drop_config.svh"

module drop_game_tb
    import drop_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT_CYCLES = 20000;  // ten turns of ~480 cycles with margin
    localparam logic [31:0] LCG_SEED = 32'h1713_0c96;

    // ball radius for each turn, in play order
    localparam int SCHEDULE [`NUM_SLOTS] = '{8'd20, 8'd15, 8'd25, 8'd10, 8'd25,
                                              8'd20, 8'd10, 8'd15, 8'd20, 8'd15};

    logic        clk;
    logic        rst;
    logic        drop;
    logic        left;
    logic        right;
    coord_t      slot_x    [`NUM_SLOTS];
    coord_t      slot_y    [`NUM_SLOTS];
    coord_t      slot_size [`NUM_SLOTS];
    logic        finish;
    logic [31:0] lcg_state;
    int          cycle_count = 0;
    int          check_count;
    int          error_count;
    int          model_x;                     // expected ball column of the current turn
    int          landed_x [`NUM_SLOTS];       // expected resting column of each turn

    drop_game_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .drop      (drop),
        .left      (left),
        .right     (right),
        .slot_x    (slot_x),
        .slot_y    (slot_y),
        .slot_size (slot_size),
        .finish    (finish)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the game did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        check_count++;
        if (actual != expected) begin
            error_count++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %s", name, (error_count == errors_before) ? "ok" : "failed");
    endtask

    // a turn has started once its slot shows the ball resting on the top line
    task automatic wait_turn_start(input int k);
        do begin
            @(negedge clk);
        end while (int'(slot_y[k]) != `UP_BOUND - SCHEDULE[k]);
    endtask

    task automatic wait_finish();
        do begin
            @(negedge clk);
        end while (!finish);
    endtask

    task automatic steer(input logic go_right, input int cycles, input int k);
        int lo;
        int hi;
        lo = `LEFT_BOUND + SCHEDULE[k];
        hi = `RIGHT_BOUND - SCHEDULE[k];
        repeat (cycles) begin
            @(posedge clk);
            right <= go_right;
            left  <= !go_right;
            if (go_right && model_x != hi) begin
                model_x++;
            end else if (!go_right && model_x != lo) begin
                model_x--;
            end
        end
        @(posedge clk);
        left  <= 1'b0;
        right <= 1'b0;
        repeat (3) @(negedge clk);            // slot lags the live ball by a cycle
    endtask

    task automatic drop_ball();
        @(posedge clk);
        drop <= 1'b1;
        @(posedge clk);
        drop <= 1'b0;
    endtask

    task automatic check_landed(input int k);
        landed_x[k] = model_x;
        check_value(slot_y[k], `FLOOR_Y - SCHEDULE[k], $sformatf("slot_y[%0d]", k));
        check_value(slot_x[k], model_x, $sformatf("slot_x[%0d]", k));
        check_value(slot_size[k], SCHEDULE[k], $sformatf("slot_size[%0d]", k));
    endtask

    task automatic reset_state_test();
        int errs;
        errs = error_count;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            check_value(slot_x[i], `EMPTY_X, $sformatf("reset slot_x[%0d]", i));
            check_value(slot_y[i], `EMPTY_Y, $sformatf("reset slot_y[%0d]", i));
            check_value(slot_size[i], `BALL_SIZE_0, $sformatf("reset slot_size[%0d]", i));
        end
        check_value(finish, 0, "finish after reset");
        report_test("reset", errs);
    endtask

    task automatic steering_test();
        int errs;
        int n;
        int m;
        errs = error_count;
        wait_turn_start(0);
        model_x = `START_X;
        n = int'((next_rand() >> 16) % 64) + 1;
        m = int'((next_rand() >> 16) % 64) + 1;
        steer(1'b1, n, 0);
        steer(1'b0, m, 0);
        check_value(slot_x[0], model_x, $sformatf("slot_x[0] after right %0d left %0d", n, m));
        report_test("steering", errs);
    endtask

    task automatic bounds_test();
        int errs;
        errs = error_count;
        steer(1'b0, 400, 0);
        check_value(slot_x[0], `LEFT_BOUND + SCHEDULE[0], "slot_x[0] at left bound");
        steer(1'b1, 400, 0);
        check_value(slot_x[0], `RIGHT_BOUND - SCHEDULE[0], "slot_x[0] at right bound");
        report_test("bounds", errs);
    endtask

    task automatic landing_test();
        int errs;
        errs = error_count;
        drop_ball();
        wait_turn_start(1);
        check_landed(0);
        check_value(finish, 0, "finish after first landing");
        report_test("landing", errs);
    endtask

    task automatic full_game_test();
        int          errs;
        logic [31:0] r;
        errs = error_count;
        for (int k = 1; k < `NUM_SLOTS; k++) begin
            wait_turn_start(k);
            model_x = `START_X;
            check_value(slot_x[k], `START_X, $sformatf("slot_x[%0d] at turn start", k));
            check_value(finish, 0, $sformatf("finish during turn %0d", k));
            r = next_rand();
            steer(r[0], int'((r >> 16) % 100) + 1, k);
            drop_ball();
            if (k < `NUM_SLOTS - 1) begin
                wait_turn_start(k + 1);
            end else begin
                wait_finish();
            end
            check_landed(k);
        end
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            check_value(slot_size[i], SCHEDULE[i], $sformatf("final slot_size[%0d]", i));
        end
        check_value(finish, 1, "finish after ten turns");
        drop_ball();                          // play on after the game is over
        repeat (100) @(negedge clk);
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            check_value(slot_x[i], landed_x[i], $sformatf("slot_x[%0d] after game over", i));
            check_value(slot_y[i], `FLOOR_Y - SCHEDULE[i],
                        $sformatf("slot_y[%0d] after game over", i));
            check_value(slot_size[i], SCHEDULE[i],
                        $sformatf("slot_size[%0d] after game over", i));
        end
        check_value(finish, 1, "finish after extra drop");
        report_test("full game", errs);
    endtask

    initial begin
        lcg_state   = LCG_SEED;
        check_count = 0;
        error_count = 0;
        rst   = 1'b1;
        drop  = 1'b0;
        left  = 1'b0;
        right = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);                       // slots still hold reset values here
        reset_state_test();
        steering_test();
        bounds_test();
        landing_test();
        full_game_test();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/drop_pkg.sv
verilog/drop_player_fsm.sv
verilog/turn_sequencer.sv
verilog/ball_slot_table.sv
verilog/drop_game_top.sv
verif/drop_game_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds and runs the drop game testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=obj_dir/drop_game_sim

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module drop_game_tb -o drop_game_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

"$SIM_BIN" > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see $SIM_LOG"
    exit 1
fi

if grep -q "^TEST PASS$" "$SIM_LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $SIM_LOG"
    exit 1
fi
